//--- hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Datapath and register file sizes
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // All-ones word stops the core
    localparam logic [DATA_W-1:0] HALT_WORD = '1;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        RTYPE = 6'd0,
        J     = 6'd2,
        BEQ   = 6'd4,
        ADDI  = 6'd8,
        LW    = 6'd35,
        SW    = 6'd43
    } opcodeE;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        ADD = 6'd32,
        SUB = 6'd34,
        AND = 6'd36,
        OR  = 6'd37,
        SLT = 6'd42
    } funcE;

    // ALU_ADD must stay zero so an all-zero ctrl is a bubble
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpE;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwdSelE;

    // Decoded control, all zero is a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;
        logic  branch;
        logic  jump;
        logic  halt;
        aluOpE aluOp;
    } ctrlT;

    // ID/EX pipeline register
    typedef struct packed {
        ctrlT                  ctrl;
        logic [DATA_W-1:0]     pcNext;
        logic [DATA_W-1:0]     rsVal;
        logic [DATA_W-1:0]     rtVal;
        logic [DATA_W-1:0]     immExt;
        logic [DATA_W-1:0]     jumpTarget;
        logic [REG_ADDR_W-1:0] rsIdx;
        logic [REG_ADDR_W-1:0] rtIdx;
        logic [REG_ADDR_W-1:0] destIdx;
    } idExT;

    // EX/MEM pipeline register
    typedef struct packed {
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  memToReg;
        logic                  halt;
        logic [DATA_W-1:0]     aluResult;
        logic [DATA_W-1:0]     storeData;
        logic [REG_ADDR_W-1:0] destIdx;
    } exMemT;

    // MEM/WB register, also the writeback and forwarding bus
    typedef struct packed {
        logic                  regWrite;
        logic [REG_ADDR_W-1:0] destIdx;
        logic [DATA_W-1:0]     data;
    } wbT;

    // Registered branch or jump decision
    typedef struct packed {
        logic              taken;
        logic [DATA_W-1:0] target;
    } redirectT;

endpackage

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                              clk,
    input  wire                              arstN,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]    rsIdx,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]    rtIdx,
    output logic [cpuPkg::DATA_W-1:0]        rsVal,
    output logic [cpuPkg::DATA_W-1:0]        rtVal,
    input  wire cpuPkg::wbT                  wb
);
    import cpuPkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wbLive;

    // Register 0 never takes a write
    assign wbLive = wb.regWrite && (wb.destIdx != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbLive) begin
            regs[wb.destIdx] <= wb.data;
        end
    end

    // Same-cycle write shows through to decode
    assign rsVal = (wbLive && wb.destIdx == rsIdx) ? wb.data : regs[rsIdx];
    assign rtVal = (wbLive && wb.destIdx == rtIdx) ? wb.data : regs[rtIdx];

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire                             clk,
    input  wire                             arstN,
    input  wire                             hold,
    input  wire cpuPkg::redirectT           redirect,
    output logic [cpuPkg::DATA_W-1:0]       imemAddr,
    input  wire  [cpuPkg::DATA_W-1:0]       imemData,
    output logic [cpuPkg::DATA_W-1:0]       ifInstr,
    output logic [cpuPkg::DATA_W-1:0]       ifPcNext
);
    import cpuPkg::*;

    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pcPlusOne;
    logic [DATA_W-1:0] pcSel;

    // Word addressed, so the next sequential PC is plus one
    assign pcPlusOne = pc + 1'b1;
    assign imemAddr  = pc;

    // Redirect wins over hold
    always_comb begin
        if (redirect.taken) begin
            pcSel = redirect.target;
        end else if (hold) begin
            pcSel = pc;
        end else begin
            pcSel = pcPlusOne;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc       <= '0;
            ifInstr  <= '0;
            ifPcNext <= '0;
        end else begin
            pc <= pcSel;
            if (redirect.taken) begin
                // Zero word decodes as a bubble
                ifInstr  <= '0;
                ifPcNext <= '0;
            end else if (!hold) begin
                ifInstr  <= imemData;
                ifPcNext <= pcPlusOne;
            end
        end
    end

    // PC stays known through stalls, halts and redirects
    pcKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(pc));

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                              clk,
    input  wire                              arstN,
    input  wire  [cpuPkg::DATA_W-1:0]        ifInstr,
    input  wire  [cpuPkg::DATA_W-1:0]        ifPcNext,
    input  wire                              stall,
    input  wire cpuPkg::redirectT            redirect,
    input  wire cpuPkg::wbT                  wb,
    output cpuPkg::idExT                     idEx,
    output logic [cpuPkg::REG_ADDR_W-1:0]    ifRsIdx,
    output logic [cpuPkg::REG_ADDR_W-1:0]    ifRtIdx,
    output logic                             halting
);
    import cpuPkg::*;

    logic [5:0]            opField;
    logic [5:0]            fnField;
    logic [REG_ADDR_W-1:0] rdIdx;
    logic [15:0]           imm16;
    logic [DATA_W-1:0]     rsVal;
    logic [DATA_W-1:0]     rtVal;
    logic                  issueBubble;
    ctrlT                  ctrl;
    idExT                  idExNext;

    // Field split
    assign opField = ifInstr[31:26];
    assign ifRsIdx = ifInstr[25:21];
    assign ifRtIdx = ifInstr[20:16];
    assign rdIdx   = ifInstr[15:11];
    assign fnField = ifInstr[5:0];
    assign imm16   = ifInstr[15:0];

    regFile uRegFile (
        .clk   (clk),
        .arstN (arstN),
        .rsIdx (ifRsIdx),
        .rtIdx (ifRtIdx),
        .rsVal (rsVal),
        .rtVal (rtVal),
        .wb    (wb)
    );

    // Control decode, unknown opcodes and functions become bubbles
    always_comb begin
        ctrl = '0;
        if (ifInstr == HALT_WORD) begin
            ctrl.halt = 1'b1;
        end else begin
            case (opcodeE'(opField))
                RTYPE: begin
                    ctrl.regWrite = 1'b1;
                    case (funcE'(fnField))
                        ADD:     ctrl.aluOp = ALU_ADD;
                        SUB:     ctrl.aluOp = ALU_SUB;
                        AND:     ctrl.aluOp = ALU_AND;
                        OR:      ctrl.aluOp = ALU_OR;
                        SLT:     ctrl.aluOp = ALU_SLT;
                        default: ctrl.regWrite = 1'b0;
                    endcase
                end
                ADDI: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
                LW: begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.memRead   = 1'b1;
                    ctrl.memToReg  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
                SW: begin
                    ctrl.memWrite  = 1'b1;
                    ctrl.aluSrcImm = 1'b1;
                end
                // Compare by subtraction, zero result means equal
                BEQ: begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = ALU_SUB;
                end
                J:       ctrl.jump = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

    always_comb begin
        idExNext.ctrl       = ctrl;
        idExNext.pcNext     = ifPcNext;
        idExNext.rsVal      = rsVal;
        idExNext.rtVal      = rtVal;
        idExNext.immExt     = {{(DATA_W-16){imm16[15]}}, imm16};
        // Absolute word target from the low 26 bits
        idExNext.jumpTarget = {{(DATA_W-26){1'b0}}, ifInstr[25:0]};
        idExNext.rsIdx      = ifRsIdx;
        idExNext.rtIdx      = ifRtIdx;
        // rd for R-type, rt otherwise, zero when nothing is written
        if (!ctrl.regWrite) begin
            idExNext.destIdx = '0;
        end else if (opField == RTYPE) begin
            idExNext.destIdx = rdIdx;
        end else begin
            idExNext.destIdx = ifRtIdx;
        end
    end

    // Squash, load-use and halt all issue a bubble
    assign issueBubble = redirect.taken | stall | halting;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx    <= '0;
            halting <= 1'b0;
        end else begin
            idEx <= issueBubble ? '0 : idExNext;
            // Older taken branch cancels a pending halt
            if (redirect.taken) begin
                halting <= 1'b0;
            end else if (!issueBubble && ctrl.halt) begin
                halting <= 1'b1;
            end
        end
    end

    // Load-use stall lasts a single cycle
    stallOnce: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> !stall);

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire cpuPkg::idExT                idEx,
    input  wire cpuPkg::exMemT               exMem,
    input  wire cpuPkg::wbT                  wb,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]    ifRsIdx,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]    ifRtIdx,
    input  wire                              halting,
    output cpuPkg::fwdSelE                   fwdA,
    output cpuPkg::fwdSelE                   fwdB,
    output logic                             stall,
    output logic                             hold
);
    import cpuPkg::*;

    // Nearest older writer wins, register 0 never forwards
    function automatic fwdSelE pickFwd(input logic [REG_ADDR_W-1:0] srcIdx,
                                       input exMemT em,
                                       input wbT mw);
        if (em.regWrite && em.destIdx != '0 && em.destIdx == srcIdx) begin
            return FWD_EXMEM;
        end else if (mw.regWrite && mw.destIdx != '0 && mw.destIdx == srcIdx) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    assign fwdA = pickFwd(idEx.rsIdx, exMem, wb);
    assign fwdB = pickFwd(idEx.rtIdx, exMem, wb);

    // Load in ID/EX feeding the word in IF/ID
    assign stall = idEx.ctrl.memRead && (idEx.destIdx != '0) &&
                   ((idEx.destIdx == ifRsIdx) || (idEx.destIdx == ifRtIdx));

    // Fetch also freezes once a halt is in flight
    assign hold = stall | halting;

    // Load address in EX/MEM never reaches an operand
    always_comb begin
        assert final (!(exMem.memRead && (fwdA == FWD_EXMEM || fwdB == FWD_EXMEM)))
            else $error("hazardUnit: load forwarded from EX/MEM before its data");
    end

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire cpuPkg::idExT       idEx,
    output cpuPkg::exMemT           exMem,
    input  wire cpuPkg::fwdSelE     fwdA,
    input  wire cpuPkg::fwdSelE     fwdB,
    input  wire cpuPkg::wbT         wb,
    output cpuPkg::redirectT        redirect
);
    import cpuPkg::*;

    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] rtFwd;
    logic [DATA_W-1:0] opB;
    logic [DATA_W-1:0] aluResult;
    logic              takeNext;
    logic [DATA_W-1:0] targetNext;
    exMemT             exMemNext;

    // Operand A source
    always_comb begin
        case (fwdA)
            FWD_EXMEM: opA = exMem.aluResult;
            FWD_MEMWB: opA = wb.data;
            default:   opA = idEx.rsVal;
        endcase
    end

    // rt value, also the store data
    always_comb begin
        case (fwdB)
            FWD_EXMEM: rtFwd = exMem.aluResult;
            FWD_MEMWB: rtFwd = wb.data;
            default:   rtFwd = idEx.rtVal;
        endcase
    end

    // addi, lw and sw take the immediate
    assign opB = idEx.ctrl.aluSrcImm ? idEx.immExt : rtFwd;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_SUB: aluResult = opA - opB;
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            // Signed compare
            ALU_SLT: aluResult = {{(DATA_W-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    // Instruction behind a taken redirect is being squashed, so it cannot redirect
    assign takeNext   = !redirect.taken &&
                        ((idEx.ctrl.branch && aluResult == '0) || idEx.ctrl.jump);
    assign targetNext = idEx.ctrl.jump ? idEx.jumpTarget : idEx.pcNext + idEx.immExt;

    always_comb begin
        exMemNext.regWrite  = idEx.ctrl.regWrite;
        exMemNext.memRead   = idEx.ctrl.memRead;
        exMemNext.memWrite  = idEx.ctrl.memWrite;
        exMemNext.memToReg  = idEx.ctrl.memToReg;
        exMemNext.halt      = idEx.ctrl.halt;
        exMemNext.aluResult = aluResult;
        exMemNext.storeData = rtFwd;
        exMemNext.destIdx   = idEx.destIdx;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            redirect <= '0;
            exMem    <= '0;
        end else begin
            redirect.taken  <= takeNext;
            redirect.target <= targetNext;
            // Squash the younger instruction leaving ID/EX
            exMem <= redirect.taken ? '0 : exMemNext;
        end
    end

    // Second younger word is gone from ID/EX after a redirect
    squashIdEx: assert property (@(posedge clk) disable iff (!arstN)
        redirect.taken |=> (idEx == '0));

endmodule

`default_nettype wire

//--- hdl/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire                         clk,
    input  wire                         arstN,
    input  wire cpuPkg::exMemT          exMem,
    output logic [cpuPkg::DATA_W-1:0]   dmemAddr,
    output logic [cpuPkg::DATA_W-1:0]   dmemWdata,
    output logic                        dmemRe,
    output logic                        dmemWe,
    input  wire  [cpuPkg::DATA_W-1:0]   dmemRdata,
    output cpuPkg::wbT                  wb,
    output logic                        halted
);
    // Data port straight from EX/MEM
    assign dmemAddr  = exMem.aluResult;
    assign dmemWdata = exMem.storeData;
    assign dmemRe    = exMem.memRead;
    assign dmemWe    = exMem.memWrite;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wb     <= '0;
            halted <= 1'b0;
        end else begin
            wb.regWrite <= exMem.regWrite;
            wb.destIdx  <= exMem.destIdx;
            // Load data or ALU result
            wb.data     <= exMem.memToReg ? dmemRdata : exMem.aluResult;
            // Sticky until reset
            if (exMem.halt) begin
                halted <= 1'b1;
            end
        end
    end

    // Only bubbles follow a halt down the pipe
    noStoreHalted: assert property (@(posedge clk) disable iff (!arstN) halted |-> !dmemWe);

endmodule

`default_nettype wire

//--- hdl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  wire                         clk,
    input  wire                         arstN,
    output logic [cpuPkg::DATA_W-1:0]   imemAddr,
    input  wire  [cpuPkg::DATA_W-1:0]   imemData,
    output logic [cpuPkg::DATA_W-1:0]   dmemAddr,
    output logic [cpuPkg::DATA_W-1:0]   dmemWdata,
    output logic                        dmemRe,
    output logic                        dmemWe,
    input  wire  [cpuPkg::DATA_W-1:0]   dmemRdata,
    output logic                        halted
);
    import cpuPkg::*;

    // IF/ID
    logic [DATA_W-1:0]     ifInstr;
    logic [DATA_W-1:0]     ifPcNext;
    logic [REG_ADDR_W-1:0] ifRsIdx;
    logic [REG_ADDR_W-1:0] ifRtIdx;
    // Pipeline registers and feedback
    idExT                  idEx;
    exMemT                 exMem;
    wbT                    wb;
    redirectT              redirect;
    // Hazard control
    fwdSelE                fwdA;
    fwdSelE                fwdB;
    logic                  stall;
    logic                  hold;
    logic                  halting;

    fetchStage uFetch (
        .clk(clk), .arstN(arstN), .hold(hold), .redirect(redirect),
        .imemAddr(imemAddr), .imemData(imemData),
        .ifInstr(ifInstr), .ifPcNext(ifPcNext)
    );

    decodeStage uDecode (
        .clk(clk), .arstN(arstN), .ifInstr(ifInstr), .ifPcNext(ifPcNext),
        .stall(stall), .redirect(redirect), .wb(wb), .idEx(idEx),
        .ifRsIdx(ifRsIdx), .ifRtIdx(ifRtIdx), .halting(halting)
    );

    hazardUnit uHazard (
        .idEx(idEx), .exMem(exMem), .wb(wb), .ifRsIdx(ifRsIdx), .ifRtIdx(ifRtIdx),
        .halting(halting), .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .hold(hold)
    );

    executeStage uExecute (
        .clk(clk), .arstN(arstN), .idEx(idEx), .exMem(exMem),
        .fwdA(fwdA), .fwdB(fwdB), .wb(wb), .redirect(redirect)
    );

    memWbStage uMemWb (
        .clk(clk), .arstN(arstN), .exMem(exMem),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemRe(dmemRe), .dmemWe(dmemWe),
        .dmemRdata(dmemRdata), .wb(wb), .halted(halted)
    );

endmodule

`default_nettype wire

//--- test/tbPrograms.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Directed programs, one row each, padded with the halt word
localparam int NUM_DIRECTED = 4;
localparam int PROG_LEN     = 16;

localparam logic [31:0] PROG_WORDS [NUM_DIRECTED][PROG_LEN] = '{
    // Dependent ALU chain, store data forwarded from both stages
    '{encodeI(ADDI, 1, 0, 5),  encodeI(ADDI, 2, 1, 3),  encodeR(SUB, 3, 2, 1),
      encodeR(AND, 4, 3, 2),   encodeR(OR, 5, 4, 3),    encodeR(SLT, 6, 1, 2),
      encodeI(ADDI, 7, 0, -4), encodeR(SLT, 4, 7, 1),   encodeI(SW, 3, 0, 0),
      encodeI(SW, 4, 0, 1),    encodeR(ADD, 2, 7, 5),   encodeI(SW, 2, 6, 2),
      encodeI(SW, 6, 2, 3),    HALT_WORD,               HALT_WORD,
      HALT_WORD},
    // Store then load, load-use on rs, rt and a load address
    '{encodeI(ADDI, 1, 0, 7),  encodeI(SW, 1, 0, 10),   encodeI(LW, 2, 0, 10),
      encodeR(ADD, 3, 2, 1),   encodeI(SW, 3, 0, 11),   encodeI(LW, 4, 0, 20),
      encodeI(SW, 4, 0, 12),   encodeI(LW, 5, 1, 0),    encodeI(LW, 6, 5, 0),
      encodeR(SUB, 7, 6, 4),   encodeI(SW, 7, 0, 13),   HALT_WORD,
      HALT_WORD,               HALT_WORD,               HALT_WORD,
      HALT_WORD},
    // Taken and not-taken beq, forward j, then a counted loop
    '{encodeI(ADDI, 1, 0, 1),  encodeI(ADDI, 2, 0, 1),  encodeI(BEQ, 2, 1, 2),
      encodeI(SW, 1, 0, 30),   encodeI(SW, 2, 0, 31),   encodeI(BEQ, 0, 1, 1),
      encodeI(SW, 1, 0, 32),   encodeJ(10),             encodeI(SW, 2, 0, 33),
      encodeI(SW, 2, 0, 34),   encodeI(ADDI, 3, 0, 3),  encodeI(ADDI, 3, 3, -1),
      encodeI(SW, 3, 3, 40),   encodeI(BEQ, 0, 3, 1),   encodeJ(11),
      HALT_WORD},
    // Writes to register 0 from addi, add and lw
    '{encodeI(ADDI, 0, 0, 55), encodeI(SW, 0, 0, 50),   encodeI(ADDI, 1, 0, -1),
      encodeR(ADD, 0, 1, 1),   encodeI(SW, 0, 1, 52),   encodeI(LW, 0, 0, 20),
      encodeI(SW, 0, 0, 53),   encodeR(OR, 2, 0, 1),    encodeI(SW, 2, 0, 54),
      HALT_WORD,               HALT_WORD,               HALT_WORD,
      HALT_WORD,               HALT_WORD,               HALT_WORD,
      HALT_WORD}
};

// Store count worked out by hand per row
localparam int PROG_STORES [NUM_DIRECTED] = '{4, 4, 4, 4};

`endif

//--- test/tbCpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpuCore;
    import cpuPkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 3;
    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 256;
    localparam int HALT_TIMEOUT = 2000;
    localparam int DRAIN_CYCLES = 8;
    localparam int MODEL_STEPS  = 4000;
    localparam int RAND_LEN     = 40;

    logic              clk;
    logic              arstN;
    logic [DATA_W-1:0] imemAddr;
    logic [DATA_W-1:0] imemData;
    logic [DATA_W-1:0] dmemAddr;
    logic [DATA_W-1:0] dmemWdata;
    logic [DATA_W-1:0] dmemRdata;
    logic              dmemRe;
    logic              dmemWe;
    logic              halted;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    // Observed and expected store streams
    logic [31:0] gotAddr [$];
    logic [31:0] gotData [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    // Observed and expected load addresses
    logic [31:0] gotLoad [$];
    logic [31:0] expLoad [$];
    logic [31:0] rngState;
    int          errorCount;
    int          checkCount;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    cpuCore u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemRe    (dmemRe),
        .dmemWe    (dmemWe),
        .dmemRdata (dmemRdata),
        .halted    (halted)
    );

    // Both memories answer in the same cycle, low address bits only
    assign imemData  = imem[imemAddr[7:0]];
    assign dmemRdata = dmem[dmemAddr[7:0]];

    // Instruction encoders
    function automatic logic [31:0] encodeR(funcE fn, int rd, int rs, int rt);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(opcodeE op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] encodeJ(int target);
        return {J, target[25:0]};
    endfunction

    `include "tbPrograms.svh"

    localparam int NUM_PROGS = NUM_DIRECTED + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Distinct word per data address
    function automatic logic [31:0] fillWord(input int addr);
        return {8'hD0, addr[7:0], ~addr[7:0], addr[7:0] ^ 8'h5A};
    endfunction

    // Store and load monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (arstN && dmemWe) begin
            checkCount++;
            assert (!halted) else begin
                errorCount++;
                $display("store seen after halted rose, address %h", dmemAddr);
            end
            gotAddr.push_back(dmemAddr);
            gotData.push_back(dmemWdata);
            dmem[dmemAddr[7:0]] = dmemWdata;
        end
        if (arstN && dmemRe) begin
            gotLoad.push_back(dmemAddr);
        end
    end

    // ALU and addi ops on r0..r7, every fourth word a store
    task automatic buildRandom();
        logic [31:0] r;
        for (int i = 0; i < RAND_LEN; i++) begin
            rngState = xorshift(rngState);
            r = rngState;
            if (i % 4 == 3) begin
                imem[i] = encodeI(SW, int'(r[2:0]), int'(r[5:3]), int'(r[10:6]));
            end else begin
                case (r[31:29])
                    3'd0, 3'd1: imem[i] = encodeI(ADDI, int'(r[2:0]), int'(r[5:3]),
                                                  int'($signed(r[25:10])));
                    3'd2: imem[i] = encodeR(ADD, int'(r[2:0]), int'(r[5:3]), int'(r[8:6]));
                    3'd3: imem[i] = encodeR(SUB, int'(r[2:0]), int'(r[5:3]), int'(r[8:6]));
                    3'd4: imem[i] = encodeR(AND, int'(r[2:0]), int'(r[5:3]), int'(r[8:6]));
                    3'd5: imem[i] = encodeR(OR, int'(r[2:0]), int'(r[5:3]), int'(r[8:6]));
                    default: imem[i] = encodeR(SLT, int'(r[2:0]), int'(r[5:3]), int'(r[8:6]));
                endcase
            end
        end
        imem[RAND_LEN] = HALT_WORD;
    endtask

    task automatic loadProgram(input int idx);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = HALT_WORD;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fillWord(i);
        end
        if (idx < NUM_DIRECTED) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                imem[i] = PROG_WORDS[idx][i];
            end
        end else begin
            buildRandom();
        end
    endtask

    // Sequential ISA model, one instruction per step, no delay slots
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] mem [DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        writes;
        int          steps;
        expAddr.delete();
        expData.delete();
        expLoad.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = fillWord(i);
        end
        pc    = '0;
        steps = 0;
        instr = imem[pc[7:0]];
        while (instr != HALT_WORD && steps < MODEL_STEPS) begin
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            imm    = {{16{instr[15]}}, instr[15:0]};
            dest   = instr[20:16];
            writes = 1'b0;
            result = '0;
            pc     = pc + 1;
            case (instr[31:26])
                RTYPE: begin
                    writes = 1'b1;
                    dest   = instr[15:11];
                    case (instr[5:0])
                        ADD:     result = a + b;
                        SUB:     result = a - b;
                        AND:     result = a & b;
                        OR:      result = a | b;
                        SLT:     result = {31'd0, $signed(a) < $signed(b)};
                        default: writes = 1'b0;
                    endcase
                end
                ADDI: begin
                    writes = 1'b1;
                    result = a + imm;
                end
                LW: begin
                    addr   = a + imm;
                    writes = 1'b1;
                    result = mem[addr[7:0]];
                    expLoad.push_back(addr);
                end
                SW: begin
                    addr = a + imm;
                    mem[addr[7:0]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                // Target relative to the following word
                BEQ: begin
                    if (a == b) begin
                        pc = pc + imm;
                    end
                end
                J:       pc = {6'd0, instr[25:0]};
                default: ;
            endcase
            if (writes && dest != 5'd0) begin
                regs[dest] = result;
            end
            steps++;
            instr = imem[pc[7:0]];
        end
        assert (instr == HALT_WORD) else begin
            errorCount++;
            $display("ISA model did not reach the halt word within %0d steps", MODEL_STEPS);
        end
    endtask

    task automatic compareStores(input int idx);
        checkCount++;
        assert (gotAddr.size() == expAddr.size()) else begin
            errorCount++;
            $display("error: dmemWe pulse count, program %0d got %h expected %h",
                     idx, gotAddr.size(), expAddr.size());
        end
        for (int i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
            checkCount++;
            assert (gotAddr[i] == expAddr[i]) else begin
                errorCount++;
                $display("error: dmemAddr, program %0d store %0d got %h expected %h",
                         idx, i, gotAddr[i], expAddr[i]);
            end
            assert (gotData[i] == expData[i]) else begin
                errorCount++;
                $display("error: dmemWdata, program %0d store %0d got %h expected %h",
                         idx, i, gotData[i], expData[i]);
            end
        end
    endtask

    task automatic compareLoads(input int idx);
        checkCount++;
        assert (gotLoad.size() == expLoad.size()) else begin
            errorCount++;
            $display("error: dmemRe pulse count, program %0d got %h expected %h",
                     idx, gotLoad.size(), expLoad.size());
        end
        for (int i = 0; i < expLoad.size() && i < gotLoad.size(); i++) begin
            checkCount++;
            assert (gotLoad[i] == expLoad[i]) else begin
                errorCount++;
                $display("error: dmemAddr, program %0d load %0d got %h expected %h",
                         idx, i, gotLoad[i], expLoad[i]);
            end
        end
    endtask

    task automatic runProgram(input int idx);
        int cycles;
        @(posedge clk);
        #DRIVE_DLY arstN = 1'b0;
        loadProgram(idx);
        gotAddr.delete();
        gotData.delete();
        gotLoad.delete();
        runModel();
        // Hand count guards the model itself
        if (idx < NUM_DIRECTED) begin
            checkCount++;
            assert (expAddr.size() == PROG_STORES[idx]) else begin
                errorCount++;
                $display("error: model store count, program %0d got %h expected %h",
                         idx, expAddr.size(), PROG_STORES[idx]);
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY arstN = 1'b1;
        checkCount++;
        assert (halted == 1'b0) else begin
            errorCount++;
            $display("error: halted after reset got %h expected %h", halted, 1'b0);
        end
        assert (dmemWe == 1'b0) else begin
            errorCount++;
            $display("error: dmemWe after reset got %h expected %h", dmemWe, 1'b0);
        end
        assert (dmemRe == 1'b0) else begin
            errorCount++;
            $display("error: dmemRe after reset got %h expected %h", dmemRe, 1'b0);
        end
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (halted) else begin
            errorCount++;
            $display("halted did not rise within %0d cycles on program %0d",
                     HALT_TIMEOUT, idx);
        end
        // Extra cycles so a stray late store gets seen
        repeat (DRAIN_CYCLES) @(negedge clk);
        compareStores(idx);
        compareLoads(idx);
    endtask

    initial begin
        arstN      = 1'b0;
        errorCount = 0;
        checkCount = 0;
        rngState   = 32'd85;
        loadProgram(0);
        for (int p = 0; p < NUM_PROGS; p++) begin
            runProgram(p);
        end
        $display("tbCpuCore: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+test
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/cpuCore.sv
test/tbCpuCore.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbCpuCore
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
